/* gba_audio_top.f */
hw/gba_audio_pkg.sv
hw/square_ctrl_if.sv
hw/square_channel.sv
hw/psg_block.sv
hw/direct_sound.sv
hw/sound_mixer.sv
hw/gba_audio_top.sv
test/tb_gba_audio.sv

/* Bender.yml */
package:
  name: gba_audio

sources:
  - hw/gba_audio_pkg.sv
  - hw/square_ctrl_if.sv
  - hw/square_channel.sv
  - hw/psg_block.sv
  - hw/direct_sound.sv
  - hw/sound_mixer.sv
  - hw/gba_audio_top.sv
  - target: test
    files:
      - test/tb_gba_audio.sv

/* test/tb_gba_audio.sv */
module tb_gba_audio;
    timeunit 1ns;
    timeprecision 1ps;
    import gba_audio_pkg::*;

    localparam int sample_div = 64;
    localparam int valid_limit = 4 * sample_div;

    logic        clk_100 = 1'b0;
    logic        reset = 1'b1;
    logic [15:0] sq1_duty_vol = '0;
    logic [15:0] sq1_freq = '0;
    logic [15:0] sq2_duty_vol = '0;
    logic [15:0] sq2_freq = '0;
    logic [15:0] sound_ctrl_l = '0;
    logic [15:0] master_ctrl = '0;
    logic [15:0] sound_ctrl_h = '0;
    logic        tm0_overflow = 1'b0;
    logic        tm1_overflow = 1'b0;
    fifo_count_t fifo_size [2] = '{default: '0};
    fifo_word_t  fifo_data [2] = '{default: '0};
    logic        fifo_re [2];
    logic        fifo_clr [2];
    logic        sound_req [2];
    sample_t     sample_left;
    sample_t     sample_right;
    logic        sample_valid;

    // FIFO models and the direct-sound reference state
    fifo_word_t  q [2][$];
    logic        fill [2] = '{default: 1'b0};
    logic        check_mix = 1'b0;
    int          rem [2];
    fifo_word_t  held [2];
    pcm8_t       exp_s [2];
    int          exp_l;
    int          exp_r;
    logic [31:0] rng_main = 32'd38416;
    logic [31:0] rng_fifo = ~32'd38416;
    int          value_errors = 0;
    int          proto_errors = 0;

    gba_audio_top #(
        .SAMPLE_DIV (sample_div),
        .STEP_DIV   (1)
    ) dut (
        .clk_100      (clk_100),
        .reset        (reset),
        .sq1_duty_vol (sq1_duty_vol),
        .sq1_freq     (sq1_freq),
        .sq2_duty_vol (sq2_duty_vol),
        .sq2_freq     (sq2_freq),
        .sound_ctrl_l (sound_ctrl_l),
        .master_ctrl  (master_ctrl),
        .sound_ctrl_h (sound_ctrl_h),
        .tm0_overflow (tm0_overflow),
        .tm1_overflow (tm1_overflow),
        .fifo_size_a  (fifo_size[0]),
        .fifo_data_a  (fifo_data[0]),
        .fifo_re_a    (fifo_re[0]),
        .fifo_clr_a   (fifo_clr[0]),
        .sound_req_a  (sound_req[0]),
        .fifo_size_b  (fifo_size[1]),
        .fifo_data_b  (fifo_data[1]),
        .fifo_re_b    (fifo_re[1]),
        .fifo_clr_b   (fifo_clr[1]),
        .sound_req_b  (sound_req[1]),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .sample_valid (sample_valid)
    );

    initial begin
        forever #5 clk_100 = ~clk_100;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_main = xorshift(rng_main);
        return rng_main;
    endfunction

    // psg side is silent whenever this model is used
    function automatic int mix_side(logic [15:0] c, pcm8_t a, pcm8_t b, bit left);
        int acc;
        int sa;
        int sb;
        acc = 0;
        sa = int'(a) * (c[2] ? 4 : 2);
        sb = int'(b) * (c[3] ? 4 : 2);
        if (left ? c[9] : c[8]) acc += sa;
        if (left ? c[13] : c[12]) acc += sb;
        return acc * 16;
    endfunction

    always @(posedge clk_100) begin
        logic ovf;
        if (reset) begin
            for (int ch = 0; ch < 2; ch++) begin
                q[ch].delete();
                rem[ch] = 0;
                exp_s[ch] = '0;
            end
            exp_l = 0;
            exp_r = 0;
        end else begin
            if (check_mix && sample_valid) begin
                assert (sample_left == sample_t'(exp_l) && sample_right == sample_t'(exp_r))
                else begin
                    $display("[ERROR] %0t: sample %0d/%0d, expected %0d/%0d", $time,
                             sample_left, sample_right, exp_l, exp_r);
                    value_errors++;
                end
            end
            // value captured by the mixer if this edge is a tick
            exp_l = mix_side(sound_ctrl_h, exp_s[0], exp_s[1], 1'b1);
            exp_r = mix_side(sound_ctrl_h, exp_s[0], exp_s[1], 1'b0);
            for (int ch = 0; ch < 2; ch++) begin
                ovf = sound_ctrl_h[ch ? snd_b_timer : snd_a_timer] ? tm1_overflow : tm0_overflow;
                assert (!(fifo_re[ch] && q[ch].size() == 0)) else begin
                    $display("channel %0d read an empty FIFO at %0t", ch, $time);
                    proto_errors++;
                end
                assert (!(fifo_re[ch] && rem[ch] != 0)) else begin
                    $display("channel %0d read a word while still holding one at %0t",
                             ch, $time);
                    proto_errors++;
                end
                assert (sound_req[ch] == (fifo_re[ch] && q[ch].size() <= 4)) else begin
                    $display("channel %0d sound request out of place at %0t", ch, $time);
                    proto_errors++;
                end
                if (fifo_clr[ch]) begin
                    q[ch].delete();
                    rem[ch] = 0;
                    exp_s[ch] = '0;
                end else begin
                    if (ovf && rem[ch] > 0) begin
                        // least significant byte plays first
                        exp_s[ch] = pcm8_t'(held[ch][8 * (4 - rem[ch]) +: 8]);
                        rem[ch]--;
                    end
                    if (fifo_re[ch]) begin
                        held[ch] = fifo_data[ch];
                        rem[ch] = 4;
                        void'(q[ch].pop_front());
                    end
                end
                if (fill[ch] && q[ch].size() < 8) begin
                    rng_fifo = xorshift(rng_fifo);
                    q[ch].push_back(rng_fifo);
                end
            end
        end
        for (int ch = 0; ch < 2; ch++) begin
            fifo_size[ch] <= fifo_count_t'(q[ch].size());
            fifo_data[ch] <= (q[ch].size() != 0) ? q[ch][0] : '0;
        end
    end

    task automatic wait_valid();
        int n;
        n = 0;
        do begin
            @(posedge clk_100);
            n++;
        end while (!sample_valid && n < valid_limit);
        if (!sample_valid) begin
            $display("no sample_valid pulse within %0d cycles", valid_limit);
            $display("Regression failed");
            $finish;
        end
    endtask

    task automatic pulse_overflow(input bit timer);
        @(posedge clk_100);
        tm0_overflow <= !timer;
        tm1_overflow <= timer;
        @(posedge clk_100);
        tm0_overflow <= 1'b0;
        tm1_overflow <= 1'b0;
    endtask

    task automatic play_overflows(input int count, input int spacing);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = next_rand();
            pulse_overflow(r[0]);
            repeat (spacing + int'(r[3:1]) * 3) @(posedge clk_100);
        end
    endtask

    initial begin
        int          permille [4];
        logic [3:0]  vol;
        logic [2:0]  mv;
        int          nonzero;
        int          level;
        int          max_l;
        int          max_r;
        int          clr_count;
        int          pulses;
        sample_t     held_left;
        logic [31:0] r;

        permille = '{125, 250, 500, 750};
        repeat (3) @(posedge clk_100);
        reset <= 1'b0;

        // square output with channel 1 routed left only
        for (int d = 0; d < 4; d++) begin
            r = next_rand();
            vol = (r[3:0] == 0) ? 4'd9 : r[3:0];
            mv = r[6:4];
            @(posedge clk_100);
            sq1_duty_vol <= {vol, 4'b0, 2'(d), 6'b0};
            sq1_freq     <= 16'd2011;
            sound_ctrl_l <= {2'b00, 2'b01, 5'b0, mv, 4'b0};
            master_ctrl  <= 16'h0080;
            sound_ctrl_h <= 16'h0002;
            wait_valid();
            wait_valid();
            nonzero = 0;
            level = int'(vol) * (int'(mv) + 1) * 16;
            // with 37-cycle steps 296 samples cover all phases
            for (int s = 0; s < 296; s++) begin
                wait_valid();
                assert ((sample_left == 0 || sample_left == level) && sample_right == 0)
                else begin
                    $display("[ERROR] %0t: square sample %0d/%0d, level %0d", $time,
                             sample_left, sample_right, level);
                    value_errors++;
                end
                if (sample_left != 0) nonzero++;
            end
            assert (nonzero * 1000 / 296 >= permille[d] - 50
                    && nonzero * 1000 / 296 <= permille[d] + 50)
            else begin
                $display("[ERROR] %0t: duty %0d high share %0d of 296", $time, d, nonzero);
                value_errors++;
            end
        end

        // random routing and volumes stay under the side maximum
        for (int i = 0; i < 20; i++) begin
            @(posedge clk_100);
            sq1_duty_vol <= 16'(next_rand()) & 16'hf0c0;
            sq2_duty_vol <= 16'(next_rand()) & 16'hf0c0;
            sq1_freq     <= 16'(next_rand()) & 16'h07ff;
            sq2_freq     <= 16'(next_rand()) & 16'h07ff;
            sound_ctrl_l <= 16'(next_rand()) & 16'h3377;
            wait_valid();
            wait_valid();
            max_l = ((sound_ctrl_l[12] ? int'(sq1_duty_vol[15:12]) : 0)
                   + (sound_ctrl_l[13] ? int'(sq2_duty_vol[15:12]) : 0))
                   * (int'(sound_ctrl_l[6:4]) + 1) * 16;
            max_r = ((sound_ctrl_l[8] ? int'(sq1_duty_vol[15:12]) : 0)
                   + (sound_ctrl_l[9] ? int'(sq2_duty_vol[15:12]) : 0))
                   * (int'(sound_ctrl_l[2:0]) + 1) * 16;
            for (int s = 0; s < 8; s++) begin
                wait_valid();
                assert (sample_left >= 0 && sample_left <= max_l
                        && sample_right >= 0 && sample_right <= max_r)
                else begin
                    $display("[ERROR] %0t: sample %0d/%0d above %0d/%0d", $time,
                             sample_left, sample_right, max_l, max_r);
                    value_errors++;
                end
            end
        end

        @(posedge clk_100);
        master_ctrl <= 16'h0000;
        repeat (sample_div + 3) @(posedge clk_100);
        for (int s = 0; s < 4; s++) begin
            wait_valid();
            assert (sample_left == 0 && sample_right == 0) else begin
                $display("[ERROR] %0t: master off, sample %0d/%0d", $time,
                         sample_left, sample_right);
                value_errors++;
            end
        end

        // direct sound against the reference model
        fill[0] <= 1'b1;
        fill[1] <= 1'b1;
        check_mix <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk_100);
            sound_ctrl_h <= 16'(next_rand()) & 16'h770f;
            play_overflows(8, 2 * sample_div + 5);
        end

        // drain both FIFOs and play out the held words before the sample must hold
        fill[0] <= 1'b0;
        fill[1] <= 1'b0;
        @(posedge clk_100);
        sound_ctrl_h <= 16'h3303;
        pulses = 0;
        while ((fifo_size[0] != 0 || fifo_size[1] != 0 || rem[0] != 0 || rem[1] != 0)
               && pulses < 64) begin
            pulse_overflow(1'b0);
            repeat (10) @(posedge clk_100);
            pulses++;
        end
        assert (fifo_size[0] == 0 && fifo_size[1] == 0 && rem[0] == 0 && rem[1] == 0)
        else begin
            $display("FIFOs did not drain during starvation");
            proto_errors++;
        end
        wait_valid();
        held_left = sample_left;
        play_overflows(6, 10);
        wait_valid();
        wait_valid();
        assert (sample_left == held_left) else begin
            $display("[ERROR] %0t: starved sample moved %0d to %0d", $time,
                     held_left, sample_left);
            value_errors++;
        end

        // FIFO reset of channel A
        fill[0] <= 1'b1;
        fill[1] <= 1'b1;
        play_overflows(10, 2 * sample_div + 5);
        @(posedge clk_100);
        sound_ctrl_h <= sound_ctrl_h | 16'h0800;
        clr_count = 0;
        repeat (12) begin
            @(posedge clk_100);
            if (fifo_clr[0]) clr_count++;
        end
        assert (clr_count == 1) else begin
            $display("FIFO reset gave %0d clear pulses instead of one", clr_count);
            proto_errors++;
        end
        sound_ctrl_h <= sound_ctrl_h & ~16'h0800;
        wait_valid();
        wait_valid();
        play_overflows(10, 2 * sample_div + 5);
        wait_valid();
        wait_valid();

        $display("errors: value %0d, protocol %0d", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* hw/gba_audio_top.sv */
module gba_audio_top #(
    parameter int SAMPLE_DIV = 2048,
    parameter int STEP_DIV   = 16
) (
    input  logic                       clk_100,
    input  logic                       reset,
    input  logic [15:0]                sq1_duty_vol,
    input  logic [15:0]                sq1_freq,
    input  logic [15:0]                sq2_duty_vol,
    input  logic [15:0]                sq2_freq,
    input  logic [15:0]                sound_ctrl_l,
    input  logic [15:0]                master_ctrl,
    input  logic [15:0]                sound_ctrl_h,
    input  logic                       tm0_overflow,
    input  logic                       tm1_overflow,
    input  gba_audio_pkg::fifo_count_t fifo_size_a,
    input  gba_audio_pkg::fifo_word_t  fifo_data_a,
    output logic                       fifo_re_a,
    output logic                       fifo_clr_a,
    output logic                       sound_req_a,
    input  gba_audio_pkg::fifo_count_t fifo_size_b,
    input  gba_audio_pkg::fifo_word_t  fifo_data_b,
    output logic                       fifo_re_b,
    output logic                       fifo_clr_b,
    output logic                       sound_req_b,
    output gba_audio_pkg::sample_t     sample_left,
    output gba_audio_pkg::sample_t     sample_right,
    output logic                       sample_valid
);
    import gba_audio_pkg::*;

    psg_level_t psg_left;
    psg_level_t psg_right;
    pcm8_t      sample_a;
    pcm8_t      sample_b;

    psg_block #(
        .STEP_DIV (STEP_DIV)
    ) u_psg (
        .clk_100      (clk_100),
        .reset        (reset),
        .sq1_duty_vol (sq1_duty_vol),
        .sq1_freq     (sq1_freq),
        .sq2_duty_vol (sq2_duty_vol),
        .sq2_freq     (sq2_freq),
        .sound_ctrl_l (sound_ctrl_l),
        .master_ctrl  (master_ctrl),
        .psg_left     (psg_left),
        .psg_right    (psg_right)
    );

    // timer select and FIFO reset come straight from sound_ctrl_h
    direct_sound ds_a (
        .clk_100      (clk_100),
        .reset        (reset),
        .timer_sel    (sound_ctrl_h[snd_a_timer]),
        .tm0_overflow (tm0_overflow),
        .tm1_overflow (tm1_overflow),
        .fifo_reset   (sound_ctrl_h[snd_a_reset]),
        .fifo_size    (fifo_size_a),
        .fifo_data    (fifo_data_a),
        .fifo_re      (fifo_re_a),
        .fifo_clr     (fifo_clr_a),
        .sound_req    (sound_req_a),
        .sample       (sample_a)
    );

    direct_sound ds_b (
        .clk_100      (clk_100),
        .reset        (reset),
        .timer_sel    (sound_ctrl_h[snd_b_timer]),
        .tm0_overflow (tm0_overflow),
        .tm1_overflow (tm1_overflow),
        .fifo_reset   (sound_ctrl_h[snd_b_reset]),
        .fifo_size    (fifo_size_b),
        .fifo_data    (fifo_data_b),
        .fifo_re      (fifo_re_b),
        .fifo_clr     (fifo_clr_b),
        .sound_req    (sound_req_b),
        .sample       (sample_b)
    );

    sound_mixer #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_mixer (
        .clk_100      (clk_100),
        .reset        (reset),
        .sound_ctrl_h (sound_ctrl_h),
        .psg_left     (psg_left),
        .psg_right    (psg_right),
        .sample_a     (sample_a),
        .sample_b     (sample_b),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .sample_valid (sample_valid)
    );

endmodule

/* hw/sound_mixer.sv */
module sound_mixer #(
    parameter int SAMPLE_DIV = 2048
) (
    input  logic                      clk_100,
    input  logic                      reset,
    input  logic [15:0]               sound_ctrl_h,
    input  gba_audio_pkg::psg_level_t psg_left,
    input  gba_audio_pkg::psg_level_t psg_right,
    input  gba_audio_pkg::pcm8_t      sample_a,
    input  gba_audio_pkg::pcm8_t      sample_b,
    output gba_audio_pkg::sample_t    sample_left,
    output gba_audio_pkg::sample_t    sample_right,
    output logic                      sample_valid
);
    import gba_audio_pkg::*;

    localparam int cnt_w = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

    logic [cnt_w-1:0]   tick_cnt;
    logic               tick;
    logic [1:0]         psg_ratio;
    logic signed [11:0] psg_l_scaled;
    logic signed [11:0] psg_r_scaled;
    logic signed [11:0] ds_a;
    logic signed [11:0] ds_b;
    logic signed [11:0] sum_l;
    logic signed [11:0] sum_r;

    function automatic logic signed [11:0] scale_psg(psg_level_t lvl, logic [1:0] ratio);
        case (ratio)
            2'd0:    return 12'(lvl >> 2);
            2'd1:    return 12'(lvl >> 1);
            default: return 12'(lvl);
        endcase
    endfunction

    function automatic logic signed [11:0] scale_ds(pcm8_t s, logic full);
        logic signed [11:0] ext;
        ext = 12'(s);
        return full ? (ext <<< 2) : (ext <<< 1);
    endfunction

    assign psg_ratio    = sound_ctrl_h[snd_psg_ratio_hi:snd_psg_ratio_lo];
    assign psg_l_scaled = scale_psg(psg_left, psg_ratio);
    assign psg_r_scaled = scale_psg(psg_right, psg_ratio);
    assign ds_a         = scale_ds(sample_a, sound_ctrl_h[snd_a_vol]);
    assign ds_b         = scale_ds(sample_b, sound_ctrl_h[snd_b_vol]);

    assign sum_l = psg_l_scaled
                 + (sound_ctrl_h[snd_a_left] ? ds_a : 12'sd0)
                 + (sound_ctrl_h[snd_b_left] ? ds_b : 12'sd0);
    assign sum_r = psg_r_scaled
                 + (sound_ctrl_h[snd_a_right] ? ds_a : 12'sd0)
                 + (sound_ctrl_h[snd_b_right] ? ds_b : 12'sd0);

    assign tick = (tick_cnt == cnt_w'(SAMPLE_DIV - 1));

    always_ff @(posedge clk_100) begin
        if (reset) begin
            tick_cnt     <= '0;
            sample_valid <= 1'b0;
            sample_left  <= '0;
            sample_right <= '0;
        end else begin
            tick_cnt     <= tick ? '0 : tick_cnt + 1'b1;
            sample_valid <= tick;
            if (tick) begin
                sample_left  <= sample_t'({sum_l, 4'b0000});
                sample_right <= sample_t'({sum_r, 4'b0000});
            end
        end
    end

    valid_single_cycle: assert property (
        @(posedge clk_100) disable iff (reset)
        sample_valid |=> !sample_valid
    );

endmodule

/* hw/direct_sound.sv */
module direct_sound (
    input  logic                       clk_100,
    input  logic                       reset,
    input  logic                       timer_sel,
    input  logic                       tm0_overflow,
    input  logic                       tm1_overflow,
    input  logic                       fifo_reset,
    input  gba_audio_pkg::fifo_count_t fifo_size,
    input  gba_audio_pkg::fifo_word_t  fifo_data,
    output logic                       fifo_re,
    output logic                       fifo_clr,
    output logic                       sound_req,
    output gba_audio_pkg::pcm8_t       sample
);
    import gba_audio_pkg::*;

    typedef enum logic {
        EMPTY,
        PLAYING
    } ds_state_t;

    ds_state_t  state;
    fifo_word_t word;
    logic [1:0] byte_idx;
    logic       reset_q;
    logic       clr_edge;
    logic       ovf;
    pcm8_t      cur_byte;

    assign ovf      = timer_sel ? tm1_overflow : tm0_overflow;
    assign clr_edge = fifo_reset && !reset_q;
    assign cur_byte = pcm8_t'(word[{byte_idx, 3'b000} +: 8]);

    // no read while the outside FIFO is being cleared
    assign fifo_re   = (state == EMPTY) && (fifo_size != '0) && !clr_edge;
    assign fifo_clr  = clr_edge;
    assign sound_req = fifo_re && (fifo_size <= fifo_count_t'(4));

    always_ff @(posedge clk_100) begin
        if (reset) begin
            state    <= EMPTY;
            byte_idx <= '0;
            sample   <= '0;
            reset_q  <= 1'b1;
        end else begin
            reset_q <= fifo_reset;
            if (clr_edge) begin
                state    <= EMPTY;
                byte_idx <= '0;
                sample   <= '0;
            end else begin
                case (state)
                    EMPTY: begin
                        if (fifo_re) begin
                            state    <= PLAYING;
                            byte_idx <= '0;
                        end
                    end
                    PLAYING: begin
                        if (ovf) begin
                            sample   <= cur_byte;
                            byte_idx <= byte_idx + 2'd1;
                            // last byte played, refetch next cycle
                            if (byte_idx == 2'd3) begin
                                state <= EMPTY;
                            end
                        end
                    end
                    default: state <= EMPTY;
                endcase
            end
        end
    end

    always_ff @(posedge clk_100) begin
        if (fifo_re) begin
            word <= fifo_data;
        end
    end

    no_read_when_empty: assert property (
        @(posedge clk_100) disable iff (reset)
        fifo_re |-> (fifo_size != '0)
    );

    clr_single_pulse: assert property (
        @(posedge clk_100) disable iff (reset)
        fifo_clr |=> !fifo_clr
    );

endmodule

/* hw/psg_block.sv */
module psg_block #(
    parameter int STEP_DIV = 16
) (
    input  logic                      clk_100,
    input  logic                      reset,
    input  logic [15:0]               sq1_duty_vol,
    input  logic [15:0]               sq1_freq,
    input  logic [15:0]               sq2_duty_vol,
    input  logic [15:0]               sq2_freq,
    input  logic [15:0]               sound_ctrl_l,
    input  logic [15:0]               master_ctrl,
    output gba_audio_pkg::psg_level_t psg_left,
    output gba_audio_pkg::psg_level_t psg_right
);
    import gba_audio_pkg::*;

    logic [15:0] duty_vol [2];
    logic [15:0] freq_reg [2];
    volume_t     level [2];
    logic [4:0]  sum_l;
    logic [4:0]  sum_r;
    logic [3:0]  gain_l;
    logic [3:0]  gain_r;

    function automatic logic [4:0] side_sum(logic [1:0] route, volume_t l0, volume_t l1);
        logic [4:0] acc;
        acc = '0;
        if (route[0]) acc = acc + 5'(l0);
        if (route[1]) acc = acc + 5'(l1);
        return acc;
    endfunction

    assign duty_vol[0] = sq1_duty_vol;
    assign duty_vol[1] = sq2_duty_vol;
    assign freq_reg[0] = sq1_freq;
    assign freq_reg[1] = sq2_freq;

    for (genvar i = 0; i < 2; i++) begin : g_sq
        square_ctrl_if ctrl_if ();

        assign ctrl_if.freq   = freq_reg[i][10:0];
        assign ctrl_if.duty   = duty_vol[i][7:6];
        assign ctrl_if.volume = duty_vol[i][15:12];
        assign ctrl_if.enable = master_ctrl[7];

        square_channel #(
            .STEP_DIV (STEP_DIV)
        ) u_sq (
            .clk_100 (clk_100),
            .reset   (reset),
            .ctrl    (ctrl_if.chan),
            .level   (level[i])
        );
    end

    assign sum_r  = side_sum(sound_ctrl_l[9:8], level[0], level[1]);
    assign sum_l  = side_sum(sound_ctrl_l[13:12], level[0], level[1]);
    // master volume 0..7 means gain 1..8
    assign gain_r = {1'b0, sound_ctrl_l[2:0]} + 4'd1;
    assign gain_l = {1'b0, sound_ctrl_l[6:4]} + 4'd1;

    always_ff @(posedge clk_100) begin
        if (reset) begin
            psg_left  <= '0;
            psg_right <= '0;
        end else begin
            psg_left  <= psg_level_t'(sum_l) * psg_level_t'(gain_l);
            psg_right <= psg_level_t'(sum_r) * psg_level_t'(gain_r);
        end
    end

    level_range: assert property (
        @(posedge clk_100) disable iff (reset)
        (psg_left <= 8'd240) && (psg_right <= 8'd240)
    );

endmodule

/* hw/square_channel.sv */
module square_channel #(
    parameter int STEP_DIV = 16
) (
    input  logic                   clk_100,
    input  logic                   reset,
    square_ctrl_if.chan            ctrl,
    output gba_audio_pkg::volume_t level
);
    import gba_audio_pkg::*;

    localparam int pre_w = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;

    logic [pre_w-1:0] pre_cnt;
    freq_t            div_cnt;
    logic [2:0]       step;
    logic             pre_done;
    logic             expire;

    assign pre_done = (pre_cnt == pre_w'(STEP_DIV - 1));

    // 2047 - freq is ~freq in 11 bits, so a step spans 2048 - freq counts
    assign expire = pre_done && (div_cnt >= ~ctrl.freq);

    always_ff @(posedge clk_100) begin
        if (reset) begin
            pre_cnt <= '0;
            div_cnt <= '0;
            step    <= '0;
        end else if (!ctrl.enable) begin
            // channel off holds the sequencer at its start
            pre_cnt <= '0;
            div_cnt <= '0;
            step    <= '0;
        end else begin
            if (pre_done) begin
                pre_cnt <= '0;
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end

            if (pre_done) begin
                if (expire) begin
                    div_cnt <= '0;
                    step    <= step + 3'd1;
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    assign level = (ctrl.enable && duty_patterns[ctrl.duty][step]) ? ctrl.volume : '0;

    // step moves only on expiry or when the channel is switched off
    step_on_expiry: assert property (
        @(posedge clk_100) disable iff (reset)
        !$stable(step) |-> $past(expire || !ctrl.enable)
    );

endmodule

/* hw/square_ctrl_if.sv */
interface square_ctrl_if;
    import gba_audio_pkg::*;

    freq_t   freq;
    duty_t   duty;
    volume_t volume;
    logic    enable;

    modport ctrl (
        output freq,
        output duty,
        output volume,
        output enable
    );

    modport chan (
        input freq,
        input duty,
        input volume,
        input enable
    );

endinterface

/* hw/gba_audio_pkg.sv */
package gba_audio_pkg;

    typedef logic [10:0]        freq_t;
    typedef logic [1:0]         duty_t;
    typedef logic [3:0]         volume_t;
    typedef logic [7:0]         psg_level_t;
    typedef logic signed [7:0]  pcm8_t;
    typedef logic signed [15:0] sample_t;
    typedef logic [31:0]        fifo_word_t;
    typedef logic [3:0]         fifo_count_t;

    // bit n is the level of duty step n
    localparam logic [7:0] duty_patterns [4] = '{
        8'b1000_0000,
        8'b1000_0001,
        8'b1110_0001,
        8'b0111_1110
    };

    // sound-control high register fields
    localparam int snd_psg_ratio_lo = 0;
    localparam int snd_psg_ratio_hi = 1;
    localparam int snd_a_vol        = 2;
    localparam int snd_b_vol        = 3;
    localparam int snd_a_right      = 8;
    localparam int snd_a_left       = 9;
    localparam int snd_a_timer      = 10;
    localparam int snd_a_reset      = 11;
    localparam int snd_b_right      = 12;
    localparam int snd_b_left       = 13;
    localparam int snd_b_timer      = 14;
    localparam int snd_b_reset      = 15;

endpackage
